// ==== Makefile ====
TOP = dfpNormalizerTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== hw/dfpNormPkg.sv ====
// decimal float normalizer shared widths, field positions, state codes and mantissa view
package dfpNormPkg;

	// --------------------
	// format sizes in digits and bits
	localparam int mantDigits = 10;
	localparam int outDigits = 7;
	localparam int expDigits = 3;

	localparam int mantW = mantDigits * 4;
	localparam int outMantW = outDigits * 4;
	localparam int expW = expDigits * 4;

	// four flags sit above exponent and mantissa in both words
	localparam int inWordW = 4 + expW + mantW;
	localparam int outWordW = 4 + expW + outMantW;

	// --------------------
	// positions inside the 4-bit flag nibble
	localparam int flagNanPos = 3;
	localparam int flagSignPos = 2;
	localparam int flagInfPos = 1;
	localparam int flagExpNegPos = 0;

	// lsb of each field in the input and output words
	localparam int inFlagsLsb = expW + mantW;
	localparam int inExpLsb = mantW;
	localparam int outFlagsLsb = expW + outMantW;
	localparam int outExpLsb = outMantW;

	// exponent 999 marks infinity and NaN
	localparam logic [expW-1:0] expMaxBcd = 12'h999;

	// leading digit count 0..10 and binary exponent 0..999
	localparam int lzCountW = 4;
	localparam int expBinW = 10;

	// --------------------
	// handshake controller state codes
	localparam int hsStateW = 3;
	localparam logic [hsStateW-1:0] stIdle = 3'd0;
	localparam logic [hsStateW-1:0] stCapture = 3'd1;
	localparam logic [hsStateW-1:0] stCompute = 3'd2;
	localparam logic [hsStateW-1:0] stPresent = 3'd3;
	localparam logic [hsStateW-1:0] stRelease = 3'd4;

	// mantissa seen as BCD digits by the scanner and as a flat vector by the shifter
	typedef union packed {
		logic [mantDigits-1:0][3:0] digits;
		logic [mantW-1:0] flat;
	} dfpMant_u;

endpackage

// ==== hw/dfpNormalizer.sv ====
// decimal floating-point normalizer top, splits the input word over scanner and decoder
`timescale 1ns/1ps

module dfpNormalizer (
	input  logic clk,
	input  logic arstN_i,
	input  logic inReq_i,
	output logic inAck_o,
	input  logic [dfpNormPkg::inWordW-1:0] inWord_i,
	output logic outReq_o,
	input  logic outAck_i,
	output logic [dfpNormPkg::outWordW-1:0] outWord_o,
	output logic inexact_o,
	output logic underflow_o
);
	import dfpNormPkg::*;

	logic captureEn;
	logic resultEn;
	dfpMant_u scanMant;
	logic [lzCountW-1:0] leadZeros;
	logic mantZero;
	logic [expW-1:0] expBcd;
	logic [expBinW-1:0] expBin;
	logic expNeg;
	logic expIsMax;
	logic isNan;
	logic isInf;
	logic sign;

	// --------------------
	// control
	normHandshake uHandshake (
		.clk(clk),
		.arstN_i(arstN_i),
		.inReq_i(inReq_i),
		.inAck_o(inAck_o),
		.outReq_o(outReq_o),
		.outAck_i(outAck_i),
		.captureEn_o(captureEn),
		.resultEn_o(resultEn)
	);

	// mantissa field goes to the scanner
	digitScan uScan (
		.clk(clk),
		.arstN_i(arstN_i),
		.captureEn_i(captureEn),
		.mant_i(inWord_i[mantW-1:0]),
		.mant_o(scanMant),
		.leadZeros_o(leadZeros),
		.mantZero_o(mantZero)
	);

	// flags and exponent go to the decoder
	expDecode uDecode (
		.clk(clk),
		.arstN_i(arstN_i),
		.captureEn_i(captureEn),
		.flags_i(inWord_i[inFlagsLsb +: 4]),
		.expBcd_i(inWord_i[inExpLsb +: expW]),
		.expBcd_o(expBcd),
		.expBin_o(expBin),
		.expNeg_o(expNeg),
		.expIsMax_o(expIsMax),
		.isNan_o(isNan),
		.isInf_o(isInf),
		.sign_o(sign)
	);

	// --------------------
	normShift uShift (
		.clk(clk),
		.arstN_i(arstN_i),
		.resultEn_i(resultEn),
		.mant_i(scanMant),
		.leadZeros_i(leadZeros),
		.mantZero_i(mantZero),
		.expBcd_i(expBcd),
		.expBin_i(expBin),
		.expNeg_i(expNeg),
		.expIsMax_i(expIsMax),
		.isNan_i(isNan),
		.isInf_i(isInf),
		.sign_i(sign),
		.outWord_o(outWord_o),
		.inexact_o(inexact_o),
		.underflow_o(underflow_o)
	);

endmodule

// ==== hw/digitScan.sv ====
// digit scanner, captures the mantissa and counts its leading zero BCD digits
`timescale 1ns/1ps

module digitScan (
	input  logic clk,
	input  logic arstN_i,
	input  logic captureEn_i,
	input  logic [39:0] mant_i,
	output dfpNormPkg::dfpMant_u mant_o,
	output logic [dfpNormPkg::lzCountW-1:0] leadZeros_o,
	output logic mantZero_o
);
	import dfpNormPkg::*;

	dfpMant_u scanView;
	logic [lzCountW-1:0] zeroCount;
	logic found;
	logic digitsLegal;

	// --------------------
	// walk from digit 9 down and stop at the first nonzero digit
	always_comb begin
		scanView = mant_i;
		found = 1'b0;
		zeroCount = '0;
		for (int i = mantDigits - 1; i >= 0; i--) begin
			if (!found) begin
				if (scanView.digits[i] != 4'd0)
					found = 1'b1;
				else
					zeroCount = zeroCount + 1'b1;
			end
		end
	end

	// mantissa payload, loaded straight from the input word
	always_ff @(posedge clk) begin
		if (captureEn_i)
			mant_o <= scanView;
	end

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			leadZeros_o <= '0;
			mantZero_o <= 1'b0;
		end else if (captureEn_i) begin
			leadZeros_o <= zeroCount;
			// all ten digits zero
			mantZero_o <= (zeroCount == lzCountW'(mantDigits));
		end
	end

	// --------------------
	// every stored digit must be 0..9
	always_comb begin
		digitsLegal = 1'b1;
		for (int i = 0; i < mantDigits; i++) begin
			if (mant_o.digits[i] > 4'd9)
				digitsLegal = 1'b0;
		end
	end

	// the producer only hands over BCD data
	assert property (@(posedge clk) disable iff (!arstN_i) captureEn_i |=> digitsLegal)
		else $error("digitScan captured a non-BCD mantissa digit");

endmodule

// ==== hw/expDecode.sv ====
// exponent decoder, converts the BCD exponent to binary and classifies the operand
`timescale 1ns/1ps

module expDecode (
	input  logic clk,
	input  logic arstN_i,
	input  logic captureEn_i,
	input  logic [3:0] flags_i,
	input  logic [dfpNormPkg::expW-1:0] expBcd_i,
	output logic [dfpNormPkg::expW-1:0] expBcd_o,
	output logic [dfpNormPkg::expBinW-1:0] expBin_o,
	output logic expNeg_o,
	output logic expIsMax_o,
	output logic isNan_o,
	output logic isInf_o,
	output logic sign_o
);
	import dfpNormPkg::*;

	logic [expBinW-1:0] binNext;
	logic isMaxNext;

	// --------------------
	// weighted digit sum, 100*d2 + 10*d1 + d0 evaluated top digit first
	always_comb begin
		binNext = '0;
		for (int i = expDigits - 1; i >= 0; i--)
			binNext = binNext * expBinW'(10) + expBinW'(expBcd_i[4*i +: 4]);
	end

	assign isMaxNext = (expBcd_i == expMaxBcd);

	// exponent payload, both encodings kept for the shifter
	always_ff @(posedge clk) begin
		if (captureEn_i) begin
			expBcd_o <= expBcd_i;
			expBin_o <= binNext;
		end
	end

	// --------------------
	// class flags
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			expNeg_o <= 1'b0;
			expIsMax_o <= 1'b0;
			isNan_o <= 1'b0;
			isInf_o <= 1'b0;
			sign_o <= 1'b0;
		end else if (captureEn_i) begin
			expNeg_o <= flags_i[flagExpNegPos];
			expIsMax_o <= isMaxNext;
			isNan_o <= flags_i[flagNanPos];
			// a positive 999 exponent already means infinity
			isInf_o <= flags_i[flagInfPos] || (isMaxNext && !flags_i[flagExpNegPos]);
			sign_o <= flags_i[flagSignPos];
		end
	end

endmodule

// ==== hw/normHandshake.sv ====
// four-phase handshake controller, sequences capture, compute and result delivery
`timescale 1ns/1ps

module normHandshake (
	input  logic clk,
	input  logic arstN_i,
	input  logic inReq_i,
	output logic inAck_o,
	output logic outReq_o,
	input  logic outAck_i,
	output logic captureEn_o,
	output logic resultEn_o
);
	import dfpNormPkg::*;

	logic [hsStateW-1:0] state;
	logic [hsStateW-1:0] stateNext;

	// --------------------
	// next state
	always_comb begin
		stateNext = state;
		case (state)
			// a new request only once the previous input ack has dropped
			stIdle: if (inReq_i && !inAck_o) stateNext = stCapture;
			stCapture: stateNext = stCompute;
			stCompute: stateNext = stPresent;
			stPresent: if (outReq_o && outAck_i) stateNext = stRelease;
			// wait for the consumer to finish its half
			stRelease: if (!outAck_i) stateNext = stIdle;
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i)
			state <= stIdle;
		else
			state <= stateNext;
	end

	// one-cycle load pulses, one after the other
	assign captureEn_o = (state == stCapture);
	assign resultEn_o = (state == stCompute);

	// --------------------
	// input ack rises once the word is captured
	// and drops after the producer releases its request
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i)
			inAck_o <= 1'b0;
		else if (state == stCompute)
			inAck_o <= 1'b1;
		else if (!inReq_i)
			inAck_o <= 1'b0;
	end

	// output request held until the consumer acks
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i)
			outReq_o <= 1'b0;
		else
			outReq_o <= (state == stPresent) && !(outReq_o && outAck_i);
	end

	// --------------------
	assert property (@(posedge clk) disable iff (!arstN_i) outReq_o && !outAck_i |=> outReq_o)
		else $error("outReq dropped before outAck was seen");

	assert property (@(posedge clk) disable iff (!arstN_i) !(captureEn_o && resultEn_o))
		else $error("capture and result load enabled together");

endmodule

// ==== hw/normShift.sv ====
// normalize stage, picks the case, shifts the mantissa, fixes the exponent and packs the result
`timescale 1ns/1ps

module normShift (
	input  logic clk,
	input  logic arstN_i,
	input  logic resultEn_i,
	input  dfpNormPkg::dfpMant_u mant_i,
	input  logic [dfpNormPkg::lzCountW-1:0] leadZeros_i,
	input  logic mantZero_i,
	input  logic [dfpNormPkg::expW-1:0] expBcd_i,
	input  logic [dfpNormPkg::expBinW-1:0] expBin_i,
	input  logic expNeg_i,
	input  logic expIsMax_i,
	input  logic isNan_i,
	input  logic isInf_i,
	input  logic sign_i,
	output logic [dfpNormPkg::outWordW-1:0] outWord_o,
	output logic inexact_o,
	output logic underflow_o
);
	import dfpNormPkg::*;

	logic [lzCountW-1:0] rAmt;
	logic [lzCountW-1:0] lAmt;
	logic [lzCountW-1:0] lzMinus1;
	logic [2*mantW-1:0] rWide;
	logic [mantW-1:0] lShifted;
	logic [expW-1:0] expDec;
	logic [expW-1:0] expInc;
	logic overflow;
	logic [3:0] flagsNext;
	logic [expW-1:0] expNext;
	logic [outMantW-1:0] mantNext;
	logic inexNext;
	logic underNext;

	// subtract one digit from a BCD exponent, borrow rippling upward
	function automatic logic [expW-1:0] bcdSub(input logic [expW-1:0] a, input logic [3:0] b);
		logic [expW-1:0] res;
		logic [4:0] diff;
		logic [3:0] sub;
		logic borrow;
		borrow = 1'b0;
		for (int i = 0; i < expDigits; i++) begin
			sub = (i == 0) ? b : 4'd0;
			diff = {1'b0, a[4*i +: 4]} - {1'b0, sub} - {4'd0, borrow};
			borrow = diff[4];
			// a negative digit wraps back into 0..9
			res[4*i +: 4] = borrow ? diff[3:0] + 4'd10 : diff[3:0];
		end
		return res;
	endfunction

	// add one to a BCD exponent
	function automatic logic [expW-1:0] bcdInc(input logic [expW-1:0] a);
		logic [expW-1:0] res;
		logic carry;
		carry = 1'b1;
		for (int i = 0; i < expDigits; i++) begin
			if (carry && a[4*i +: 4] == 4'd9) begin
				res[4*i +: 4] = 4'd0;
			end else begin
				res[4*i +: 4] = a[4*i +: 4] + {3'd0, carry};
				carry = 1'b0;
			end
		end
		return res;
	endfunction

	// --------------------
	// shift amounts
	// right shift by e-1 digits on a negative exponent, zero otherwise
	always_comb begin
		rAmt = '0;
		if (expNeg_i) begin
			if (expBin_i > expBinW'(mantDigits + 1))
				rAmt = lzCountW'(mantDigits);
			else if (expBin_i != '0)
				rAmt = lzCountW'(expBin_i - 1'b1);
		end
	end

	// left shift keeps one whole digit and never takes the exponent below zero
	assign lzMinus1 = leadZeros_i - 1'b1;
	assign lAmt = (expBin_i < expBinW'(lzMinus1)) ? lzCountW'(expBin_i) : lzMinus1;

	// low half of the wide word catches the digits shifted out on the right
	assign rWide = {mant_i.flat, {mantW{1'b0}}} >> {rAmt, 2'b00};
	assign lShifted = mant_i.flat << {lAmt, 2'b00};

	assign expDec = bcdSub(expBcd_i, lAmt);
	assign expInc = bcdInc(expBcd_i);

	// carried whole digit on top of exponent 999
	assign overflow = !expNeg_i && (leadZeros_i == '0) && expIsMax_i;

	// --------------------
	// case select in priority order
	always_comb begin
		flagsNext = '0;
		flagsNext[flagSignPos] = sign_i;
		expNext = '0;
		mantNext = '0;
		inexNext = 1'b0;
		underNext = 1'b0;
		if (isNan_i || isInf_i || overflow) begin
			// fixed special encoding
			flagsNext[flagNanPos] = isNan_i;
			flagsNext[flagInfPos] = isInf_i || overflow;
			expNext = expMaxBcd;
		end else if (mantZero_i) begin
			// clean zero, only the sign survives
			expNext = '0;
		end else if (expNeg_i) begin
			// denormal with exponent forced to zero
			mantNext = rWide[2*mantW-1 -: outMantW];
			inexNext = |rWide[2*mantW-outMantW-1:0];
			underNext = 1'b1;
		end else if (leadZeros_i == '0) begin
			// two whole digits, drop the low ones and bump the exponent
			mantNext = rWide[2*mantW-1 -: outMantW];
			inexNext = |rWide[2*mantW-outMantW-1:0];
			expNext = expInc;
		end else begin
			mantNext = lShifted[mantW-5 -: outMantW];
			inexNext = |lShifted[mantW-outMantW-5:0];
			expNext = expDec;
		end
	end

	// --------------------
	// result register, held while the output handshake waits
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			outWord_o <= '0;
			inexact_o <= 1'b0;
			underflow_o <= 1'b0;
		end else if (resultEn_i) begin
			outWord_o[outFlagsLsb +: 4] <= flagsNext;
			outWord_o[outExpLsb +: expW] <= expNext;
			outWord_o[0 +: outMantW] <= mantNext;
			inexact_o <= inexNext;
			underflow_o <= underNext;
		end
	end

	// a denormal never shifts past the whole mantissa
	assert property (@(posedge clk) disable iff (!arstN_i)
		resultEn_i && expNeg_i |-> rAmt <= lzCountW'(mantDigits))
		else $error("normShift right shift exceeds the mantissa width");

endmodule

// ==== sources.f ====
hw/dfpNormPkg.sv
hw/digitScan.sv
hw/expDecode.sv
hw/normShift.sv
hw/normHandshake.sv
hw/dfpNormalizer.sv
test/dfpNormalizerTb.sv

// ==== test/dfpNormalizerTb.sv ====
// testbench for the decimal float normalizer driving a vector table through both four-phase handshakes
`timescale 1ns/1ps

module dfpNormalizerTb;
	import dfpNormPkg::*;

	// wait limit in clock cycles for every handshake edge
	localparam int waitLimit = 50;
	localparam int selInAck = 0;
	localparam int selOutReq = 1;

	logic clk = 1'b0;
	logic arstN_i;
	logic inReq_i;
	logic inAck_o;
	logic [inWordW-1:0] inWord_i;
	logic outReq_o;
	logic outAck_i;
	logic [outWordW-1:0] outWord_o;
	logic inexact_o;
	logic underflow_o;

	// vector table columns
	string nameQ[$];
	logic [inWordW-1:0] inQ[$];
	logic [outWordW-1:0] outQ[$];
	logic inexQ[$];
	logic underQ[$];
	int holdQ[$];

	dfpNormalizer uut (
		.clk(clk),
		.arstN_i(arstN_i),
		.inReq_i(inReq_i),
		.inAck_o(inAck_o),
		.inWord_i(inWord_i),
		.outReq_o(outReq_o),
		.outAck_i(outAck_i),
		.outWord_o(outWord_o),
		.inexact_o(inexact_o),
		.underflow_o(underflow_o)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// --------------------
	// append one table row where hold counts the cycles outAck_i is held back
	task automatic addRow(input string name, input logic [inWordW-1:0] inWord,
		input logic [outWordW-1:0] outWord, input logic inex, input logic under, input int hold);
		nameQ.push_back(name);
		inQ.push_back(inWord);
		outQ.push_back(outWord);
		inexQ.push_back(inex);
		underQ.push_back(under);
		holdQ.push_back(hold);
	endtask

	function automatic logic handshakeLine(input int sel);
		return (sel == selInAck) ? inAck_o : outReq_o;
	endfunction

	// sampled on falling edges where DUT outputs are settled
	task automatic waitLevel(input int sel, input logic level, input string what);
		int cycles;
		cycles = 0;
		while (handshakeLine(sel) !== level && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (handshakeLine(sel) !== level) begin
			$display("Timeout: the %s handshake hung, no change after %0d cycles", what, waitLimit);
			$display("Testbench failed");
			$fatal(1, "handshake timeout");
		end
	endtask

	task automatic checkValue(input string name, input string field,
		input logic [63:0] expected, input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("** Error %s %s: expected %h, actual %h", name, field, expected, actual);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// --------------------
	initial begin
		int i;

		arstN_i = 1'b0;
		inReq_i = 1'b0;
		inWord_i = '0;
		outAck_i = 1'b0;

		// flag nibble nan sign inf expNeg then 3 exponent digits then the mantissa
		// carried whole digit raises the exponent by one
		addRow("carryInexact", 56'h0_012_1234567890, 44'h0_013_1234567, 1'b1, 1'b0, 5);
		addRow("carryExact", 56'h4_045_9876543000, 44'h4_046_9876543, 1'b0, 1'b0, 0);
		addRow("carryTo999", 56'h0_998_1234567000, 44'h0_999_1234567, 1'b0, 1'b0, 0);
		// one leading zero needs no shift
		addRow("noShift", 56'h0_100_0123456789, 44'h0_100_1234567, 1'b1, 1'b0, 0);
		addRow("leftShift", 56'h0_050_0001234567, 44'h0_048_1234567, 1'b0, 1'b0, 0);
		// exponent 101 minus 5 borrows through two digits
		addRow("leftBorrow", 56'h0_101_0000001234, 44'h0_096_1234000, 1'b0, 1'b0, 0);
		// shift stops at exponent zero
		addRow("leftLimit", 56'h0_002_0000012345, 44'h0_000_0012345, 1'b0, 1'b0, 0);
		// negative exponents give denormals
		addRow("denormInexact", 56'h1_003_1234567890, 44'h0_000_0012345, 1'b1, 1'b1, 0);
		addRow("denormExact", 56'h5_001_0500000000, 44'h4_000_0500000, 1'b0, 1'b1, 0);
		addRow("denormFlush", 56'h1_020_0000000007, 44'h0_000_0000000, 1'b1, 1'b1, 0);
		// specials
		addRow("nanPass", 56'hC_123_1234567890, 44'hC_999_0000000, 1'b0, 1'b0, 0);
		addRow("infPass", 56'h2_000_1000000000, 44'h2_999_0000000, 1'b0, 1'b0, 0);
		addRow("exp999", 56'h0_999_0123456789, 44'h2_999_0000000, 1'b0, 1'b0, 0);
		addRow("incPast999", 56'h0_999_1234567890, 44'h2_999_0000000, 1'b0, 1'b0, 0);
		addRow("zeroSigned", 56'h4_456_0000000000, 44'h4_000_0000000, 1'b0, 1'b0, 0);

		// --------------------
		// reset for 4 cycles and release on a falling edge
		repeat (4) @(negedge clk);
		arstN_i = 1'b1;
		@(negedge clk);
		checkValue("reset", "inAck_o", 64'(1'b0), 64'(inAck_o));
		checkValue("reset", "outReq_o", 64'(1'b0), 64'(outReq_o));
		checkValue("reset", "outWord_o", 64'(0), 64'(outWord_o));
		checkValue("reset", "inexact_o", 64'(1'b0), 64'(inexact_o));
		checkValue("reset", "underflow_o", 64'(1'b0), 64'(underflow_o));

		for (i = 0; i < nameQ.size(); i++) begin
			// the word may already be on the bus after a back-pressure row
			inWord_i = inQ[i];
			inReq_i = 1'b1;
			waitLevel(selInAck, 1'b1, "input (inAck_o rise)");
			inReq_i = 1'b0;
			waitLevel(selInAck, 1'b0, "input (inAck_o fall)");

			// output side
			waitLevel(selOutReq, 1'b1, "output (outReq_o rise)");
			checkValue(nameQ[i], "outWord_o", 64'(outQ[i]), 64'(outWord_o));
			checkValue(nameQ[i], "inexact_o", 64'(inexQ[i]), 64'(inexact_o));
			checkValue(nameQ[i], "underflow_o", 64'(underQ[i]), 64'(underflow_o));

			// under back-pressure the next word is offered early and must not be taken
			if (holdQ[i] > 0 && i + 1 < nameQ.size()) begin
				inWord_i = inQ[i + 1];
				inReq_i = 1'b1;
			end
			repeat (holdQ[i]) begin
				@(negedge clk);
				checkValue(nameQ[i], "held outWord_o", 64'(outQ[i]), 64'(outWord_o));
				checkValue(nameQ[i], "held inexact_o", 64'(inexQ[i]), 64'(inexact_o));
				checkValue(nameQ[i], "held underflow_o", 64'(underQ[i]), 64'(underflow_o));
				checkValue(nameQ[i], "held outReq_o", 64'(1'b1), 64'(outReq_o));
				checkValue(nameQ[i], "early inAck_o", 64'(1'b0), 64'(inAck_o));
			end

			outAck_i = 1'b1;
			waitLevel(selOutReq, 1'b0, "output (outReq_o fall)");
			outAck_i = 1'b0;
		end

		$display("Testbench passed");
		$finish;
	end

endmodule
